// File: Bender.yml
package:
  name: dma_ctrl

sources:
  - files:
      - logic/dma_ctrl_pkg.sv
      - logic/trans_alloc_if.sv
      - logic/cmd_entry_if.sv
      - logic/ctrl_target_fsm.sv
      - logic/trans_status_regs.sv
      - logic/cmd_queue.sv
      - logic/dma_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_dma_ctrl.sv

// File: filelist.f
logic/dma_ctrl_pkg.sv
logic/trans_alloc_if.sv
logic/cmd_entry_if.sv
logic/ctrl_target_fsm.sv
logic/trans_status_regs.sv
logic/cmd_queue.sv
logic/dma_ctrl_top.sv
testbench/tb_dma_ctrl.sv

// File: logic/cmd_entry_if.sv
//************************************************
// One assembled DMA command, sequencer to queue
//************************************************
`timescale 1ns/1ps
`default_nettype none

interface cmd_entry_if import dma_ctrl_pkg::*; ();

   logic       valid;
   logic       ready;       // Queue not full
   len_t       len;         // Length minus one
   opc_t       opc;
   logic       inc;
   tcdm_addr_t tcdm_add;
   ext_addr_t  ext_add;
   sid_t       sid;

   modport prod (output valid, len, opc, inc, tcdm_add, ext_add, sid,
                 input  ready);

   modport cons (input  valid, len, opc, inc, tcdm_add, ext_add, sid,
                 output ready);

endinterface

`default_nettype wire

// File: logic/cmd_queue.sv
//************************************************
// Command FIFO toward the transfer engine
//************************************************
`timescale 1ns/1ps
`default_nettype none

module cmd_queue import dma_ctrl_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   cmd_entry_if.cons  in,
   output logic       cmd_valid_o,
   input  logic       cmd_ready_i,
   output len_t       cmd_len_o,
   output opc_t       cmd_opc_o,
   output logic       cmd_inc_o,
   output tcdm_addr_t cmd_tcdm_add_o,
   output ext_addr_t  cmd_ext_add_o,
   output sid_t       cmd_sid_o
);

   len_t       len_mem  [CMD_QUEUE_DEPTH];
   opc_t       opc_mem  [CMD_QUEUE_DEPTH];
   logic       inc_mem  [CMD_QUEUE_DEPTH];
   tcdm_addr_t tcdm_mem [CMD_QUEUE_DEPTH];
   ext_addr_t  ext_mem  [CMD_QUEUE_DEPTH];
   sid_t       sid_mem  [CMD_QUEUE_DEPTH];

   logic [QPTR_WIDTH-1:0] rd_ptr_q, wr_ptr_q;
   logic [QCNT_WIDTH-1:0] count_q;
   logic                  full, push, pop;

   assign full        = (count_q == QCNT_WIDTH'(CMD_QUEUE_DEPTH));
   assign in.ready    = !full;
   assign cmd_valid_o = (count_q != '0);
   assign push        = in.valid & in.ready;
   assign pop         = cmd_valid_o & cmd_ready_i;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= (wr_ptr_q == QPTR_WIDTH'(CMD_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == QPTR_WIDTH'(CMD_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + QCNT_WIDTH'(push) - QCNT_WIDTH'(pop);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         len_mem[wr_ptr_q]  <= in.len;
         opc_mem[wr_ptr_q]  <= in.opc;
         inc_mem[wr_ptr_q]  <= in.inc;
         tcdm_mem[wr_ptr_q] <= in.tcdm_add;
         ext_mem[wr_ptr_q]  <= in.ext_add;
         sid_mem[wr_ptr_q]  <= in.sid;
      end
   end

   // Head entry
   assign cmd_len_o      = len_mem[rd_ptr_q];
   assign cmd_opc_o      = opc_mem[rd_ptr_q];
   assign cmd_inc_o      = inc_mem[rd_ptr_q];
   assign cmd_tcdm_add_o = tcdm_mem[rd_ptr_q];
   assign cmd_ext_add_o  = ext_mem[rd_ptr_q];
   assign cmd_sid_o      = sid_mem[rd_ptr_q];

   // Pointers meet only on an empty or a full queue
   assert property (@(posedge clk_i) disable iff (!rst_ni)
                    (wr_ptr_q == rd_ptr_q) == (!cmd_valid_o || full));

   assert property (@(posedge clk_i) disable iff (!rst_ni)
                    cmd_valid_o && !cmd_ready_i |=> cmd_valid_o &&
                    $stable({cmd_len_o, cmd_opc_o, cmd_inc_o,
                             cmd_tcdm_add_o, cmd_ext_add_o, cmd_sid_o}));

endmodule

`default_nettype wire

// File: logic/ctrl_target_fsm.sv
//************************************************
// Target port decoder and three-word command
// sequencer with registered response
//************************************************
`timescale 1ns/1ps
`default_nettype none

module ctrl_target_fsm import dma_ctrl_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       targ_req_i,
   input  logic       targ_we_i,
   input  reg_addr_t  targ_addr_i,
   input  word_t      targ_wdata_i,
   input  pe_id_t     targ_id_i,
   output logic       targ_gnt_o,
   output logic       targ_rvalid_o,
   output word_t      targ_rdata_o,
   output pe_id_t     targ_rid_o,
   trans_alloc_if.seq alloc,
   cmd_entry_if.prod  cmd
);

   seq_state_e state_q, state_d;
   logic       gnt, accept;
   logic       cmd_hit, status_hit;
   logic       alloc_req, clr_valid, push_req;
   logic       len_en, tcdm_en;
   word_t      rdata_d, status_word;
   logic       rvalid_q;
   word_t      rdata_q;
   pe_id_t     rid_q;
   sid_t       sid_q;
   len_t       len_q;
   opc_t       opc_q;
   logic       inc_q;
   tcdm_addr_t tcdm_q;

   assign cmd_hit    = (targ_addr_i == CMD_REG_OFFSET);
   assign status_hit = (targ_addr_i == STATUS_REG_OFFSET);
   assign accept     = targ_req_i & gnt;

   always_comb
   begin
      status_word                                   = '0;
      status_word[NB_TRANSFERS-1:0]                 = alloc.busy_bits;   // In flight
      status_word[STATUS_ALLOC_LSB +: NB_TRANSFERS] = alloc.alloc_bits;
   end

   //************************************************
   // Decode and sequencing
   //************************************************
   always_comb
   begin
      state_d   = state_q;
      gnt       = 1'b0;
      rdata_d   = '0;
      alloc_req = 1'b0;
      clr_valid = 1'b0;
      push_req  = 1'b0;
      len_en    = 1'b0;
      tcdm_en   = 1'b0;
      if (targ_req_i)
      begin
         gnt = 1'b1;
         if (status_hit)
         begin
            // Status access is served in any state but ends an open sequence
            state_d = IDLE;
            if (targ_we_i)
               clr_valid = 1'b1;
            else
               rdata_d = status_word;
         end
         else
         begin
            unique case (state_q)
               IDLE:
               begin
                  if (cmd_hit && !targ_we_i)
                  begin
                     alloc_req = 1'b1;
                     gnt       = alloc.alloc_gnt;           // Stall until an ID is free
                     rdata_d   = word_t'(alloc.alloc_sid);
                     state_d   = WAIT_CMD;
                  end
               end
               WAIT_CMD:
               begin
                  len_en  = cmd_hit & targ_we_i;
                  state_d = len_en ? WAIT_TCDM : IDLE;
               end
               WAIT_TCDM:
               begin
                  tcdm_en = cmd_hit & targ_we_i;
                  state_d = tcdm_en ? WAIT_EXT : IDLE;
               end
               WAIT_EXT:
               begin
                  state_d = IDLE;
                  if (cmd_hit && targ_we_i)
                  begin
                     push_req = 1'b1;
                     gnt      = cmd.ready;                  // Stall on full queue
                  end
               end
               default: state_d = IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q  <= IDLE;
         rvalid_q <= 1'b0;
      end
      else
      begin
         rvalid_q <= accept;                                // One response per grant
         if (accept)
            state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         rdata_q <= rdata_d;
         rid_q   <= targ_id_i;
      end
      if (alloc_req && alloc.alloc_gnt)
         sid_q <= alloc.alloc_sid;
      if (len_en)
      begin
         len_q <= targ_wdata_i[LEN_WIDTH-1:0] - len_t'(1);
         opc_q <= targ_wdata_i[OPC_BIT];
         inc_q <= targ_wdata_i[INC_BIT];
      end
      if (tcdm_en)
         tcdm_q <= targ_wdata_i[TCDM_ADD_WIDTH-1:0];
   end

   assign targ_gnt_o    = gnt;
   assign targ_rvalid_o = rvalid_q;
   assign targ_rdata_o  = rdata_q;
   assign targ_rid_o    = rid_q;

   assign alloc.alloc_req  = alloc_req;
   assign alloc.clr_valid  = clr_valid;
   assign alloc.clr_mask   = targ_wdata_i[NB_TRANSFERS-1:0];
   assign alloc.mark_valid = push_req & cmd.ready;
   assign alloc.mark_sid   = sid_q;

   assign cmd.valid    = push_req;
   assign cmd.len      = len_q;
   assign cmd.opc      = opc_q;
   assign cmd.inc      = inc_q;
   assign cmd.tcdm_add = tcdm_q;
   assign cmd.ext_add  = targ_wdata_i[EXT_ADD_WIDTH-1:0];   // Last word goes straight through
   assign cmd.sid      = sid_q;

   // A handed out ID must be free in the status registers
   assert property (@(posedge clk_i) disable iff (!rst_ni)
                    alloc_req && alloc.alloc_gnt |-> !alloc.alloc_bits[alloc.alloc_sid]);

endmodule

`default_nettype wire

// File: logic/dma_ctrl_pkg.sv
//************************************************
// Widths, register map, field positions, types
// and sequencer states of the DMA command front end
//************************************************
`default_nettype none

package dma_ctrl_pkg;

   localparam int unsigned NB_TRANSFERS    = 4;
   localparam int unsigned SID_WIDTH       = 2;
   localparam int unsigned WORD_WIDTH      = 32;
   localparam int unsigned REG_ADDR_WIDTH  = 4;
   localparam int unsigned LEN_WIDTH       = 16;
   localparam int unsigned TCDM_ADD_WIDTH  = 12;
   localparam int unsigned EXT_ADD_WIDTH   = 29;
   localparam int unsigned CMD_QUEUE_DEPTH = 2;
   localparam int unsigned QPTR_WIDTH      = (CMD_QUEUE_DEPTH > 1) ? $clog2(CMD_QUEUE_DEPTH) : 1;
   localparam int unsigned QCNT_WIDTH      = $clog2(CMD_QUEUE_DEPTH + 1);

   typedef logic [SID_WIDTH-1:0]      sid_t;
   typedef logic [NB_TRANSFERS-1:0]   sid_mask_t;       // One bit per transfer ID
   typedef logic [WORD_WIDTH-1:0]     word_t;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic                      pe_id_t;
   typedef logic [LEN_WIDTH-1:0]      len_t;
   typedef logic                      opc_t;            // 0 read from ext, 1 write to ext
   typedef logic [TCDM_ADD_WIDTH-1:0] tcdm_addr_t;
   typedef logic [EXT_ADD_WIDTH-1:0]  ext_addr_t;

   // Register offsets on the target port
   localparam reg_addr_t CMD_REG_OFFSET    = 4'h0;
   localparam reg_addr_t STATUS_REG_OFFSET = 4'h4;

   localparam int unsigned OPC_BIT          = 16;     // Command word opcode
   localparam int unsigned INC_BIT          = 17;     // Command word incremental flag
   localparam int unsigned STATUS_ALLOC_LSB = 16;     // Allocated bitmap in status word

   typedef enum logic [1:0] {IDLE, WAIT_CMD, WAIT_TCDM, WAIT_EXT} seq_state_e;

endpackage

`default_nettype wire

// File: logic/dma_ctrl_top.sv
//************************************************
// DMA command front end top level
//************************************************
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_top import dma_ctrl_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   // Target port
   input  logic       targ_req_i,
   input  logic       targ_we_i,
   input  reg_addr_t  targ_addr_i,
   input  word_t      targ_wdata_i,
   input  pe_id_t     targ_id_i,
   output logic       targ_gnt_o,
   output logic       targ_rvalid_o,
   output word_t      targ_rdata_o,
   output pe_id_t     targ_rid_o,
   // Command port
   output logic       cmd_valid_o,
   input  logic       cmd_ready_i,
   output len_t       cmd_len_o,
   output opc_t       cmd_opc_o,
   output logic       cmd_inc_o,
   output tcdm_addr_t cmd_tcdm_add_o,
   output ext_addr_t  cmd_ext_add_o,
   output sid_t       cmd_sid_o,
   // Completion from transfer engine
   input  logic       done_valid_i,
   input  sid_t       done_sid_i,
   output logic       busy_o
);

   trans_alloc_if i_alloc_if ();
   cmd_entry_if   i_cmd_if ();

   ctrl_target_fsm i_ctrl_target_fsm (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .targ_req_i    (targ_req_i),
      .targ_we_i     (targ_we_i),
      .targ_addr_i   (targ_addr_i),
      .targ_wdata_i  (targ_wdata_i),
      .targ_id_i     (targ_id_i),
      .targ_gnt_o    (targ_gnt_o),
      .targ_rvalid_o (targ_rvalid_o),
      .targ_rdata_o  (targ_rdata_o),
      .targ_rid_o    (targ_rid_o),
      .alloc         (i_alloc_if.seq),
      .cmd           (i_cmd_if.prod)
   );

   trans_status_regs i_trans_status_regs (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .alloc        (i_alloc_if.regs),
      .done_valid_i (done_valid_i),
      .done_sid_i   (done_sid_i),
      .busy_o       (busy_o)
   );

   cmd_queue i_cmd_queue (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .in             (i_cmd_if.cons),
      .cmd_valid_o    (cmd_valid_o),
      .cmd_ready_i    (cmd_ready_i),
      .cmd_len_o      (cmd_len_o),
      .cmd_opc_o      (cmd_opc_o),
      .cmd_inc_o      (cmd_inc_o),
      .cmd_tcdm_add_o (cmd_tcdm_add_o),
      .cmd_ext_add_o  (cmd_ext_add_o),
      .cmd_sid_o      (cmd_sid_o)
   );

endmodule

`default_nettype wire

// File: logic/trans_alloc_if.sv
//************************************************
// ID allocation, clear and in-flight marking link
//************************************************
`timescale 1ns/1ps
`default_nettype none

interface trans_alloc_if import dma_ctrl_pkg::*; ();

   logic      alloc_req;
   logic      alloc_gnt;    // Some ID is free
   sid_t      alloc_sid;    // Lowest free ID
   sid_mask_t alloc_bits;
   sid_mask_t busy_bits;
   logic      clr_valid;
   sid_mask_t clr_mask;
   logic      mark_valid;
   sid_t      mark_sid;

   modport seq  (output alloc_req, clr_valid, clr_mask, mark_valid, mark_sid,
                 input  alloc_gnt, alloc_sid, alloc_bits, busy_bits);
   modport regs (input  alloc_req, clr_valid, clr_mask, mark_valid, mark_sid,
                 output alloc_gnt, alloc_sid, alloc_bits, busy_bits);

endinterface

`default_nettype wire

// File: logic/trans_status_regs.sv
//************************************************
// ID allocator with allocated and in-flight
// status bitmaps
//************************************************
`timescale 1ns/1ps
`default_nettype none

module trans_status_regs import dma_ctrl_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_ni,
   trans_alloc_if.regs alloc,
   input  logic        done_valid_i,
   input  sid_t        done_sid_i,
   output logic        busy_o
);

   sid_mask_t alloc_q, alloc_d;
   sid_mask_t busy_q, busy_d;
   sid_t      free_sid;
   logic      any_free;

   // Lowest free ID wins
   always_comb
   begin
      free_sid = '0;
      any_free = 1'b0;
      for (int i = NB_TRANSFERS - 1; i >= 0; i--)
      begin
         if (!alloc_q[i])
         begin
            free_sid = sid_t'(i);
            any_free = 1'b1;
         end
      end
   end

   always_comb
   begin
      alloc_d = alloc_q;
      if (alloc.clr_valid)
         alloc_d = alloc_d & ~alloc.clr_mask;
      if (alloc.alloc_req && any_free)
         alloc_d[free_sid] = 1'b1;
   end

   always_comb
   begin
      busy_d = busy_q;
      if (done_valid_i)
         busy_d[done_sid_i] = 1'b0;                         // Engine finished
      if (alloc.mark_valid)
         busy_d[alloc.mark_sid] = 1'b1;                     // Command enqueued
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         alloc_q <= '0;
         busy_q  <= '0;
      end
      else
      begin
         alloc_q <= alloc_d;
         busy_q  <= busy_d;
      end
   end

   assign alloc.alloc_gnt  = any_free;
   assign alloc.alloc_sid  = free_sid;
   assign alloc.alloc_bits = alloc_q;
   assign alloc.busy_bits  = busy_q;
   assign busy_o           = |busy_q;

   // Completions only come for transfers that were enqueued
   assert property (@(posedge clk_i) disable iff (!rst_ni)
                    done_valid_i |-> busy_q[done_sid_i]);

endmodule

`default_nettype wire

// File: testbench/tb_dma_ctrl.sv
//************************************************
// Directed testbench of the DMA command front end
// Clock, DUT, reference model, compare tasks,
// tests and cycle timeout
//************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_dma_ctrl import dma_ctrl_pkg::*;
();

   localparam int NUM_ACCESSES   = 70;                      // Target accesses over all tests
   localparam int TIMEOUT_CYCLES = 20 * NUM_ACCESSES + 200;

   typedef struct packed {
      len_t       len;
      opc_t       opc;
      logic       inc;
      tcdm_addr_t tcdm_add;
      ext_addr_t  ext_add;
      sid_t       sid;
   } cmd_t;

   logic       clk_i, rst_ni;
   logic       targ_req_i, targ_we_i, targ_gnt_o, targ_rvalid_o;
   reg_addr_t  targ_addr_i;
   word_t      targ_wdata_i, targ_rdata_o;
   pe_id_t     targ_id_i, targ_rid_o;
   logic       cmd_valid_o, cmd_ready_i, cmd_inc_o;
   len_t       cmd_len_o;
   opc_t       cmd_opc_o;
   tcdm_addr_t cmd_tcdm_add_o;
   ext_addr_t  cmd_ext_add_o;
   sid_t       cmd_sid_o;
   logic       done_valid_i, busy_o;
   sid_t       done_sid_i;

   sid_mask_t  exp_alloc = '0;                              // Model of the status bitmaps
   sid_mask_t  exp_busy  = '0;
   cmd_t       exp_q[$];
   cmd_t       got_q[$];
   word_t      rng_state = 32'd33965;
   int         cycle_cnt = 0;

   dma_ctrl_top i_dma_ctrl_top (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .targ_req_i     (targ_req_i),
      .targ_we_i      (targ_we_i),
      .targ_addr_i    (targ_addr_i),
      .targ_wdata_i   (targ_wdata_i),
      .targ_id_i      (targ_id_i),
      .targ_gnt_o     (targ_gnt_o),
      .targ_rvalid_o  (targ_rvalid_o),
      .targ_rdata_o   (targ_rdata_o),
      .targ_rid_o     (targ_rid_o),
      .cmd_valid_o    (cmd_valid_o),
      .cmd_ready_i    (cmd_ready_i),
      .cmd_len_o      (cmd_len_o),
      .cmd_opc_o      (cmd_opc_o),
      .cmd_inc_o      (cmd_inc_o),
      .cmd_tcdm_add_o (cmd_tcdm_add_o),
      .cmd_ext_add_o  (cmd_ext_add_o),
      .cmd_sid_o      (cmd_sid_o),
      .done_valid_i   (done_valid_i),
      .done_sid_i     (done_sid_i),
      .busy_o         (busy_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES)
         fail_run("timeout, the tests did not complete within the cycle limit");
   end

   // Commands leaving the queue, sampled mid cycle
   always @(negedge clk_i)
   begin
      if (rst_ni && cmd_valid_o && cmd_ready_i)
         got_q.push_back({cmd_len_o, cmd_opc_o, cmd_inc_o, cmd_tcdm_add_o,
                          cmd_ext_add_o, cmd_sid_o});
   end

   //************************************************
   // Reporting and compare tasks
   //************************************************
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("error: %s expected 0x%0h got 0x%0h", name, exp, got);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t got);
      if (got !== exp)
         report_mismatch(name, exp, got);
   endtask

   task automatic check_sid(input string name, input sid_t exp, input sid_t got);
      if (got !== exp)
         report_mismatch(name, exp, got);
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp)
         report_mismatch(name, exp, got);
   endtask

   task automatic check_cmd(input cmd_t exp, input cmd_t got);
      if (got.len !== exp.len)
         report_mismatch("cmd_len_o", exp.len, got.len);
      if (got.opc !== exp.opc)
         report_mismatch("cmd_opc_o", exp.opc, got.opc);
      if (got.inc !== exp.inc)
         report_mismatch("cmd_inc_o", exp.inc, got.inc);
      if (got.tcdm_add !== exp.tcdm_add)
         report_mismatch("cmd_tcdm_add_o", exp.tcdm_add, got.tcdm_add);
      if (got.ext_add !== exp.ext_add)
         report_mismatch("cmd_ext_add_o", exp.ext_add, got.ext_add);
      if (got.sid !== exp.sid)
         report_mismatch("cmd_sid_o", exp.sid, got.sid);
   endtask

   //************************************************
   // Model and target port helpers
   //************************************************
   function automatic word_t xorshift32(input word_t x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic sid_t lowest_free(input sid_mask_t used);
      sid_t sid;
      logic found;
      sid   = '0;
      found = 1'b0;
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         if (!found && !used[i])
         begin
            sid   = sid_t'(i);
            found = 1'b1;
         end
      end
      return sid;
   endfunction

   function automatic word_t expected_status();
      word_t w;
      w                                   = '0;
      w[NB_TRANSFERS-1:0]                 = exp_busy;
      w[STATUS_ALLOC_LSB +: NB_TRANSFERS] = exp_alloc;
      return w;
   endfunction

   task automatic start_req(input logic we, input reg_addr_t addr, input word_t wdata,
                            input pe_id_t pe);
      @(posedge clk_i);
      #1;
      targ_req_i   = 1'b1;
      targ_we_i    = we;
      targ_addr_i  = addr;
      targ_wdata_i = wdata;
      targ_id_i    = pe;
   endtask

   // Waits for the grant, then takes the response one cycle later
   task automatic finish_req(output word_t rdata, output pe_id_t rid);
      @(negedge clk_i);
      check_bit("targ_rvalid_o", 1'b0, targ_rvalid_o);
      while (!targ_gnt_o)
      begin
         @(negedge clk_i);
         check_bit("targ_rvalid_o", 1'b0, targ_rvalid_o);
      end
      @(posedge clk_i);
      #1;
      targ_req_i = 1'b0;
      @(negedge clk_i);
      check_bit("targ_rvalid_o", 1'b1, targ_rvalid_o);
      rdata = targ_rdata_o;
      rid   = targ_rid_o;
   endtask

   task automatic access(input logic we, input reg_addr_t addr, input word_t wdata,
                         input pe_id_t pe, input word_t exp_rdata);
      word_t  rdata;
      pe_id_t rid;
      start_req(we, addr, wdata, pe);
      finish_req(rdata, rid);
      check_word("targ_rdata_o", exp_rdata, rdata);
      check_bit("targ_rid_o", pe, rid);
   endtask

   task automatic expect_no_grant(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk_i);
         check_bit("targ_gnt_o", 1'b0, targ_gnt_o);
      end
   endtask

   // Returns the ID that the DUT handed out
   task automatic cmd_read(input pe_id_t pe, output sid_t sid);
      word_t  rdata;
      pe_id_t rid;
      start_req(1'b0, CMD_REG_OFFSET, '0, pe);
      finish_req(rdata, rid);
      check_word("targ_rdata_o", word_t'(lowest_free(exp_alloc)), rdata);
      check_bit("targ_rid_o", pe, rid);
      sid            = sid_t'(rdata);
      exp_alloc[sid] = 1'b1;
   endtask

   task automatic status_read(input pe_id_t pe);
      access(1'b0, STATUS_REG_OFFSET, '0, pe, expected_status());
   endtask

   task automatic status_write(input sid_mask_t mask);
      access(1'b1, STATUS_REG_OFFSET, 32'h5a5a_0000 | word_t'(mask), 1'b0, '0);
      exp_alloc = exp_alloc & ~mask;
   endtask

   // Full three word sequence, optionally stalling the last write on a full queue
   task automatic send_command(input pe_id_t pe, input word_t cmd_word, input word_t tcdm_word,
                               input word_t ext_word, input int stall_cycles,
                               output sid_t sid);
      cmd_t   exp;
      word_t  rdata;
      pe_id_t rid;
      cmd_read(pe, sid);
      exp.len      = cmd_word[LEN_WIDTH-1:0] - 16'd1;
      exp.opc      = cmd_word[OPC_BIT];
      exp.inc      = cmd_word[INC_BIT];
      exp.tcdm_add = tcdm_word[TCDM_ADD_WIDTH-1:0];
      exp.ext_add  = ext_word[EXT_ADD_WIDTH-1:0];
      exp.sid      = sid;
      access(1'b1, CMD_REG_OFFSET, cmd_word, pe, '0);
      access(1'b1, CMD_REG_OFFSET, tcdm_word, pe, '0);
      start_req(1'b1, CMD_REG_OFFSET, ext_word, pe);
      if (stall_cycles > 0)
      begin
         expect_no_grant(stall_cycles);
         @(posedge clk_i);
         #1;
         cmd_ready_i = 1'b1;                                // Engine starts taking commands
      end
      finish_req(rdata, rid);
      check_word("targ_rdata_o", '0, rdata);
      check_bit("targ_rid_o", pe, rid);
      exp_q.push_back(exp);
      exp_busy[sid] = 1'b1;
   endtask

   task automatic drain_commands();
      while (got_q.size() < exp_q.size())
         @(posedge clk_i);
      while (exp_q.size() > 0)
         check_cmd(exp_q.pop_front(), got_q.pop_front());
   endtask

   task automatic complete_transfer(input sid_t sid);
      @(posedge clk_i);
      #1;
      done_valid_i = 1'b1;
      done_sid_i   = sid;
      @(posedge clk_i);
      #1;
      done_valid_i  = 1'b0;
      exp_busy[sid] = 1'b0;
      @(negedge clk_i);
      check_bit("busy_o", |exp_busy, busy_o);
   endtask

   //************************************************
   // Tests
   //************************************************
   task automatic reset_values();
      @(negedge clk_i);
      check_bit("cmd_valid_o", 1'b0, cmd_valid_o);
      check_bit("busy_o", 1'b0, busy_o);
      check_bit("targ_rvalid_o", 1'b0, targ_rvalid_o);
      status_read(1'b0);
   endtask

   task automatic full_sequence();
      sid_t sid;
      send_command(1'b1, 32'hfff8_0040 | (32'd1 << OPC_BIT), 32'hffff_fabc,
                   32'hf234_5678, 0, sid);
      check_sid("alloc sid", 2'd0, sid);
      drain_commands();
      status_read(1'b0);                                    // Bits 0 and 16
      @(negedge clk_i);
      check_bit("busy_o", 1'b1, busy_o);
      complete_transfer(sid);
      status_read(1'b0);
      status_write(4'hf);
   endtask

   task automatic alloc_and_clear();
      sid_t sid;
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         cmd_read(1'b0, sid);
         check_sid("alloc sid", sid_t'(i), sid);
         status_read(1'b0);                                 // Ends the open sequence
      end
      start_req(1'b0, CMD_REG_OFFSET, '0, 1'b0);
      expect_no_grant(20);
      @(posedge clk_i);
      #1;
      targ_req_i = 1'b0;                                    // Withdraw the stalled read
      @(negedge clk_i);
      check_bit("targ_rvalid_o", 1'b0, targ_rvalid_o);
      status_write(4'b0100);
      cmd_read(1'b1, sid);
      check_sid("alloc sid", 2'd2, sid);
      status_read(1'b0);
      status_write(4'hf);
   endtask

   task automatic queue_backpressure();
      sid_t sid;
      @(posedge clk_i);
      #1;
      cmd_ready_i = 1'b0;
      for (int i = 0; i < CMD_QUEUE_DEPTH; i++)
      begin
         send_command(1'b0, 32'h0000_0100 + i, 32'h0000_0200 + i, 32'h0010_0000 + i, 0, sid);
         check_sid("alloc sid", sid_t'(i), sid);
      end
      @(negedge clk_i);
      check_bit("cmd_valid_o", 1'b1, cmd_valid_o);
      send_command(1'b1, 32'h0003_0300, 32'h0000_0333, 32'h0030_0000, 20, sid);
      drain_commands();
      for (int i = 0; i <= CMD_QUEUE_DEPTH; i++)
         complete_transfer(sid_t'(i));
      status_write(4'hf);
   endtask

   task automatic sequence_abort();
      sid_t sid;
      int   seen;
      seen = got_q.size();
      cmd_read(1'b0, sid);
      access(1'b1, CMD_REG_OFFSET, 32'h0000_0010, 1'b0, '0);
      status_read(1'b1);                                    // Abort in WAIT_TCDM
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      check_bit("cmd_valid_o", 1'b0, cmd_valid_o);
      if (got_q.size() != seen)
         fail_run("a command left the queue after an aborted sequence");
      status_read(1'b0);                                    // ID still allocated
      status_write(4'hf);
   endtask

   task automatic random_commands();
      sid_t  sid;
      word_t cmd_word, tcdm_word, ext_word;
      repeat (6)
      begin
         rng_state = xorshift32(rng_state);
         cmd_word  = rng_state;
         rng_state = xorshift32(rng_state);
         tcdm_word = rng_state;
         rng_state = xorshift32(rng_state);
         ext_word  = rng_state;
         send_command(rng_state[31], cmd_word, tcdm_word, ext_word, 0, sid);
         drain_commands();
         complete_transfer(sid);
         status_write(sid_mask_t'(1) << sid);
      end
   endtask

   initial
   begin
      rst_ni       = 1'b0;
      targ_req_i   = 1'b0;
      targ_we_i    = 1'b0;
      targ_addr_i  = '0;
      targ_wdata_i = '0;
      targ_id_i    = 1'b0;
      cmd_ready_i  = 1'b1;
      done_valid_i = 1'b0;
      done_sid_i   = '0;
      repeat (10) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;

      reset_values();
      full_sequence();
      alloc_and_clear();
      queue_backpressure();
      sequence_abort();
      random_commands();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire
